//--- Bender.yml
package:
  name: correlator

sources:
  - files:
      - verilog/xc_pkg.sv
      - verilog/xc_if.sv
      - verilog/uart_rx.sv
      - verilog/uart_tx.sv
      - verilog/xc_control.sv
      - verilog/integration_timer.sv
      - verilog/pulse_counters.sv
      - verilog/frame_sender.sv
      - verilog/correlator.sv
  - target: test
    files:
      - bench/correlator_asserts.sv
      - bench/correlator_tb.sv

//--- bench/correlator_asserts.sv
// sampled on the rising clock edge and silent while rst_n is low, bound to every correlator
`timescale 1ns/1ps
`default_nettype none

module correlator_asserts (
	input wire clki,
	input wire rst_n,
	input wire pulse, // integration_clk_pulse
	input wire tx,
	input wire busy,  // frame sender busy
	input wire run
);
	// one cycle per window end
	pulse_single: assert property (@(posedge clki) disable iff (!rst_n) pulse |=> !pulse)
		else $error("integration_clk_pulse high two cycles in a row");

	// line idles high between frames
	tx_idle: assert property (@(posedge clki) disable iff (!rst_n) !busy |-> tx)
		else $error("tx low while the frame sender is idle");

	// timer held while stopped, so no pulse in the cycle after either
	stopped_quiet: assert property (@(posedge clki) disable iff (!rst_n) !run |=> !pulse)
		else $error("integration_clk_pulse right after run was low");

endmodule

bind correlator correlator_asserts asserts0 (
	.clki(clki),
	.rst_n(rst_n),
	.pulse(integration_clk_pulse),
	.tx(tx),
	.busy(snap_if.busy),
	.run(cfg_if.run)
);

`default_nettype wire

//--- bench/correlator_tb.sv
// 10 clocks per UART bit and 100 per tick, dut1 shares rx and pulse_in and has 8-bit counters
`timescale 1ns/1ps
`default_nettype none

module correlator_tb;
	localparam int NI       = 4;
	localparam int NC       = 6;              // pairs of 4 lines
	localparam int CPB      = 10;             // 50 MHz over 5 Mbaud
	localparam int WIN      = 40 * 100;       // integ_ticks 40
	localparam int RUN_LAT  = 3 + CPB / 2 + 9 * CPB + 1; // start bit to run high
	localparam int WAIT_MAX = 3 * WIN;

	logic          clki;
	logic          rst_n;
	logic          rx;
	logic [NI-1:0] pulse_in;
	wire           tx0, tx1;
	wire           pulse0, pulse1;
	wire [2*NI-1:0] active0, active1;
	wire [NI-1:0]  ovf0, ovf1;

	int            seed = 51;
	int            cyc = 0;         // posedge count
	int            rx_start_cyc;    // cycle of the last start bit sent
	int            errors = 0;
	int            checks = 0;
	logic [NI-1:0] en_m;            // model copy of the masks
	logic [NI-1:0] inv_m;
	logic [NI-1:0] lvl_q;           // model edge register
	int            line_cnt[NI];
	int            pair_cnt[NC];
	int            exp_line[4][NI]; // per window, for the frames
	int            exp_pair[4][NC];

	correlator #(.BAUD_RATE(5_000_000), .TICK_CYCLES(100), .NUM_INPUTS(NI)) dut0 (
		.clki(clki), .rst_n(rst_n), .rx(rx), .pulse_in(pulse_in), .tx(tx0),
		.integration_clk_pulse(pulse0), .active_line(active0), .overflow(ovf0));

	// small counters saturate inside one window
	correlator #(
		.BAUD_RATE(5_000_000), .TICK_CYCLES(100), .NUM_INPUTS(NI), .RESOLUTION(8)
	) dut1 (
		.clki(clki), .rst_n(rst_n), .rx(rx), .pulse_in(pulse_in), .tx(tx1),
		.integration_clk_pulse(pulse1), .active_line(active1), .overflow(ovf1));

	initial begin
		clki = 1'b0;
		forever #10 clki = ~clki;
	end

	always @(posedge clki) cyc <= cyc + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	function automatic logic [2*NI-1:0] interleave(input logic [NI-1:0] en, input logic [NI-1:0] inv);
		logic [2*NI-1:0] r;
		for (int a = 0; a < NI; a++) begin
			r[2*a]   = en[a];  // enable on even bits
			r[2*a+1] = inv[a];
		end
		return r;
	endfunction

	function automatic logic tx_line(input int sel);
		return sel ? tx1 : tx0;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// UART side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(negedge clki);
			if (i == 0) rx_start_cyc = cyc;
			rx = bits[i];
			repeat (CPB - 1) @(negedge clki);
		end
	endtask

	task automatic set_masks(input logic [NI-1:0] en, input logic [NI-1:0] inv);
		send_byte(xc_pkg::op_set_enable);
		send_byte(8'(en));
		send_byte(xc_pkg::op_set_invert);
		send_byte(8'(inv));
		en_m  = en;
		inv_m = inv;
		lvl_q = pulse_in ^ inv; // inputs sit idle while stopped
	endtask

	task automatic receive_byte(input int sel, output logic [7:0] b, output bit ok);
		int n;
		bit start_low;
		n = 0;
		b = '0;
		ok = 1'b0;
		start_low = 1'b0;
		while (!start_low && n < WAIT_MAX) begin
			@(negedge clki);
			start_low = !tx_line(sel);
			n++;
		end
		if (!start_low) begin
			note_failure($sformatf("dut%0d sent no start bit on tx before the timeout", sel));
			return;
		end
		repeat (CPB / 2) @(negedge clki); // middle of the start bit
		if (tx_line(sel)) begin
			note_failure($sformatf("dut%0d start bit on tx ended early", sel));
			return;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CPB) @(negedge clki);
			b[i] = tx_line(sel); // lsb first
		end
		repeat (CPB) @(negedge clki);
		if (!tx_line(sel)) begin
			note_failure($sformatf("dut%0d stop bit on tx was low", sel));
			return;
		end
		ok = 1'b1;
	endtask

	// header, lines 0 up, pairs in upper-triangle order, high byte first
	task automatic receive_frame(input int sel, input int w);
		int         nb;
		int         maxv;
		int         got;
		int         exp;
		logic [7:0] b;
		bit         ok;
		nb   = sel ? 1 : 2;
		maxv = sel ? 255 : 65535;
		receive_byte(sel, b, ok);
		if (!ok) return;
		check_val($sformatf("dut%0d frame %0d header", sel, w), b, 8'hA5);
		for (int k = 0; k < NI + NC; k++) begin
			got = 0;
			for (int m = 0; m < nb; m++) begin
				receive_byte(sel, b, ok);
				if (!ok) return;
				got = (got << 8) | b;
			end
			exp = (k < NI) ? exp_line[w][k] : exp_pair[w][k-NI];
			if (exp > maxv) exp = maxv; // saturated count
			if (k < NI) check_val($sformatf("dut%0d line_count[%0d] w%0d", sel, k, w), got, exp);
			else check_val($sformatf("dut%0d pair_count[%0d] w%0d", sel, k - NI, w), got, exp);
		end
	endtask

	task automatic receive_frames(input int sel, input int first, input int n);
		for (int w = first; w < first + n; w++) receive_frame(sel, w);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic clear_model();
		for (int a = 0; a < NI; a++) line_cnt[a] = 0;
		for (int p = 0; p < NC; p++) pair_cnt[p] = 0;
	endtask

	// one clock of inputs, counting the rising edges after polarity and enable
	task automatic drive_cycle(input logic [NI-1:0] v);
		logic [NI-1:0] lvl;
		logic [NI-1:0] rise;
		int            p;
		@(negedge clki);
		pulse_in = v;
		lvl   = v ^ inv_m;
		rise  = lvl & ~lvl_q & en_m;
		lvl_q = lvl;
		p = 0;
		for (int i = 0; i < NI; i++) begin
			if (rise[i]) line_cnt[i]++;
			for (int j = i + 1; j < NI; j++) begin
				if (rise[i] && rise[j]) pair_cnt[p]++; // (0,1) (0,2) .. (1,2) ..
				p++;
			end
		end
	endtask

	// every level lasts 2 cycles or more, together moves a random subset at once
	task automatic drive_random(input int n, input bit together);
		logic [NI-1:0] v;
		int            age[NI];
		int            hold;
		v = '0;
		hold = 0;
		for (int a = 0; a < NI; a++) age[a] = 2;
		repeat (n) begin
			if (together) begin
				if (hold > 0) hold--;
				else begin
					v    = (v != '0) ? '0 : NI'($random(seed));
					hold = 1 + ($random(seed) & 3);
				end
			end else begin
				for (int a = 0; a < NI; a++) begin
					if (age[a] >= 2 && ($random(seed) & 1)) begin
						v[a]   = ~v[a];
						age[a] = 1;
					end else age[a]++;
				end
			end
			drive_cycle(v);
		end
		drive_cycle(v); // last level also held 2 cycles
	endtask

	task automatic wait_pulse(output int at);
		int n;
		n = 0;
		at = -1;
		while (at < 0 && n < WAIT_MAX) begin
			@(negedge clki);
			if (pulse0) at = cyc;
			n++;
		end
		if (at < 0) note_failure("integration_clk_pulse did not come before the timeout");
	endtask

	// quiet first and last cycles of each window, so latency never moves an edge
	task automatic run_windows(input int first, input int n, input bit together, input int c0);
		int at;
		int prev;
		prev = c0 + RUN_LAT; // run rises here
		for (int w = first; w < first + n; w++) begin
			repeat (12) drive_cycle('0);
			drive_random(WIN - 40, together);
			wait_pulse(at);
			check_val("integration_clk_pulse spacing", at - prev, WIN);
			check_val("dut1 integration_clk_pulse", pulse1, 1'b1);
			prev = at;
			for (int a = 0; a < NI; a++) begin
				check_val($sformatf("dut1 overflow[%0d]", a), ovf1[a], line_cnt[a] >= 255);
				check_val($sformatf("dut0 overflow[%0d]", a), ovf0[a], 1'b0);
				exp_line[w][a] = line_cnt[a];
			end
			for (int p = 0; p < NC; p++) exp_pair[w][p] = pair_cnt[p];
			clear_model();
			drive_cycle('0);
			check_val("dut1 overflow after window", ovf1, '0); // cleared by window_end
		end
	endtask

	task automatic watch_quiet(input int n);
		int pulses;
		int low_tx;
		pulses = 0;
		low_tx = 0;
		for (int k = 0; k < n; k++) begin
			@(negedge clki);
			if (pulse0 || pulse1) pulses++;
			if (!tx0 || !tx1) low_tx++;
		end
		checks++;
		if (pulses != 0) note_failure("integration_clk_pulse seen after op_stop");
		if (low_tx != 0) note_failure("a frame went out on tx after op_stop");
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		logic [NI-1:0] en_rand;
		logic [NI-1:0] inv_rand;
		int            c0;
		rst_n    = 1'b0;
		rx       = 1'b1; // uart idle
		pulse_in = '0;
		en_m     = '1;
		inv_m    = '0;
		lvl_q    = '0;
		clear_model();
		repeat (5) @(posedge clki);
		@(negedge clki);
		rst_n = 1'b1;
		@(negedge clki);
		check_val("dut0 active_line", active0, interleave('1, '0));

		en_rand  = NI'($random(seed));
		en_rand[0]    = 1'b1;          // one line surely counts
		en_rand[NI-1] = 1'b0;          // and one surely reads zero
		inv_rand = NI'($random(seed));
		set_masks(en_rand, inv_rand);
		repeat (2) @(negedge clki);
		check_val("dut0 active_line", active0, interleave(en_rand, inv_rand));
		check_val("dut1 active_line", active1, interleave(en_rand, inv_rand));

		send_byte(xc_pkg::op_set_time);
		send_byte(8'h00);
		send_byte(8'd40);
		send_byte(xc_pkg::op_start);
		c0 = rx_start_cyc;
		fork
			run_windows(0, 3, 1'b0, c0);
			receive_frames(0, 0, 3);
			receive_frames(1, 0, 3);
		join

		// coincidences, all lines on and no inversion
		send_byte(xc_pkg::op_stop);
		set_masks('1, '0);
		send_byte(xc_pkg::op_start);
		c0 = rx_start_cyc;
		fork
			run_windows(3, 1, 1'b1, c0);
			receive_frames(0, 3, 1);
			receive_frames(1, 3, 1);
		join

		send_byte(xc_pkg::op_stop);
		watch_quiet(10000);

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) $display("TEST RESULT: PASS");
		else $display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
verilog/xc_pkg.sv
verilog/xc_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/xc_control.sv
verilog/integration_timer.sv
verilog/pulse_counters.sv
verilog/frame_sender.sv
verilog/correlator.sv
bench/correlator_asserts.sv
bench/correlator_tb.sv

//--- verilog/correlator.sv
// no PLL and no pulse outputs, NUM_INPUTS between 2 and 8 and RESOLUTION a multiple of 8
`timescale 1ns/1ps
`default_nettype none

module correlator #(
	parameter int CLK_FREQUENCY = 50_000_000,
	parameter int BAUD_RATE     = 57600,
	parameter int TICK_CYCLES   = 50000,    // clocks per window tick
	parameter int RESOLUTION    = 16,
	parameter int NUM_INPUTS    = 4
) (
	input  wire                    clki,
	input  wire                    rst_n,
	input  wire                    rx,
	input  wire [NUM_INPUTS-1:0]   pulse_in,
	output wire                    tx,
	output wire                    integration_clk_pulse,
	output wire [2*NUM_INPUTS-1:0] active_line,  // enable at 2a, invert at 2a+1
	output wire [NUM_INPUTS-1:0]   overflow
);
	localparam int NUM_CORRELATORS = xc_pkg::num_pairs(NUM_INPUTS);

	wire [7:0] rx_data;
	wire       rx_valid;
	wire       window_end;
	wire       tx_start;
	wire [7:0] tx_data;
	wire       tx_busy;

	xc_cfg_if #(.NUM_INPUTS(NUM_INPUTS)) cfg_if ();
	xc_snap_if #(
		.NUM_INPUTS(NUM_INPUTS), .NUM_CORRELATORS(NUM_CORRELATORS), .RESOLUTION(RESOLUTION)
	) snap_if ();

	uart_rx #(.CLK_FREQUENCY(CLK_FREQUENCY), .BAUD_RATE(BAUD_RATE)) rx0 (
		.clki(clki), .rst_n(rst_n), .rx(rx), .data(rx_data), .valid(rx_valid));

	xc_control #(.NUM_INPUTS(NUM_INPUTS)) ctrl0 (
		.clki(clki), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid), .cfg(cfg_if.ctrl));

	integration_timer #(.TICK_CYCLES(TICK_CYCLES)) timer0 (
		.clki(clki), .rst_n(rst_n), .cfg(cfg_if.user), .window_end(window_end));

	pulse_counters #(
		.NUM_INPUTS(NUM_INPUTS), .NUM_CORRELATORS(NUM_CORRELATORS), .RESOLUTION(RESOLUTION)
	) counters0 (
		.clki(clki), .rst_n(rst_n), .pulse_in(pulse_in), .window_end(window_end),
		.cfg(cfg_if.user), .snp(snap_if.src), .overflow(overflow));

	frame_sender #(
		.NUM_INPUTS(NUM_INPUTS), .NUM_CORRELATORS(NUM_CORRELATORS), .RESOLUTION(RESOLUTION)
	) sender0 (
		.clki(clki), .rst_n(rst_n), .snp(snap_if.dst),
		.tx_start(tx_start), .tx_data(tx_data), .tx_busy(tx_busy));

	uart_tx #(.CLK_FREQUENCY(CLK_FREQUENCY), .BAUD_RATE(BAUD_RATE)) tx0 (
		.clki(clki), .rst_n(rst_n), .start(tx_start), .data(tx_data), .tx(tx), .busy(tx_busy));

	assign integration_clk_pulse = window_end;

	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_active
		assign active_line[2*a]   = cfg_if.line_enable[a];
		assign active_line[2*a+1] = cfg_if.line_invert[a];
	end

endmodule

`default_nettype wire

//--- verilog/frame_sender.sv
// RESOLUTION must be a multiple of 8 and a snap arriving while busy is high is dropped whole
`timescale 1ns/1ps
`default_nettype none

module frame_sender #(
	parameter int NUM_INPUTS      = 4,
	parameter int NUM_CORRELATORS = 6,
	parameter int RESOLUTION      = 16
) (
	input  wire        clki,
	input  wire        rst_n,
	xc_snap_if.dst     snp,
	output logic       tx_start,
	output logic [7:0] tx_data,
	input  wire        tx_busy
);
	localparam int FRAME_BYTES = xc_pkg::frame_bytes(NUM_INPUTS, NUM_CORRELATORS, RESOLUTION);
	localparam int FRAME_W     = FRAME_BYTES * 8;
	localparam int BCNT_W      = $clog2(FRAME_BYTES + 1);

	typedef enum logic [1:0] {fs_idle, fs_send, fs_wait} fs_state_e;

	fs_state_e          state;
	logic [FRAME_W-1:0] frame;   // header on top, counts msb first below
	logic [FRAME_W-1:0] shift_q; // bytes leave from the top
	logic [BCNT_W-1:0]  left;    // bytes still to go

	always_comb begin
		frame = '0;
		frame[FRAME_W-1 -: 8] = xc_pkg::FRAME_HEADER;
		for (int a = 0; a < NUM_INPUTS; a++)
			frame[FRAME_W-9-a*RESOLUTION -: RESOLUTION] = snp.line_count[a*RESOLUTION +: RESOLUTION];
		for (int p = 0; p < NUM_CORRELATORS; p++)
			frame[FRAME_W-9-(NUM_INPUTS+p)*RESOLUTION -: RESOLUTION] =
				snp.pair_count[p*RESOLUTION +: RESOLUTION];
	end

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			state <= fs_idle;
			left  <= '0;
		end else begin
			case (state)
				fs_idle: if (snp.snap) begin
					state <= fs_send;
					left  <= BCNT_W'(FRAME_BYTES);
				end
				fs_send: state <= fs_wait;  // uart_tx takes the byte here
				fs_wait: if (!tx_busy) begin // stop bit finished
					left <= left - 1'b1;
					if (left == BCNT_W'(1)) state <= fs_idle;
					else state <= fs_send;
				end
				default: state <= fs_idle;
			endcase
		end
	end

	always_ff @(posedge clki) begin
		if (state == fs_idle && snp.snap) shift_q <= frame;
		else if (state == fs_wait && !tx_busy) shift_q <= shift_q << 8;
	end

	assign tx_start = (state == fs_send);
	assign tx_data  = shift_q[FRAME_W-1 -: 8];
	assign snp.busy = (state != fs_idle);

endmodule

`default_nettype wire

//--- verilog/integration_timer.sv
// window_end comes integ_ticks*TICK_CYCLES clocks after run rises and a new integ_ticks applies from the next window
`timescale 1ns/1ps
`default_nettype none

module integration_timer #(
	parameter int TICK_CYCLES = 50000
) (
	input  wire     clki,
	input  wire     rst_n,
	xc_cfg_if.user  cfg,
	output logic    window_end
);
	localparam int PRE_W = $clog2(TICK_CYCLES + 1);
	localparam int TW    = xc_pkg::TIME_W;

	logic [PRE_W-1:0] pre;      // clocks within the tick
	logic [TW-1:0]    ticks;    // ticks within the window
	logic [TW-1:0]    limit;    // integ_ticks taken at window start
	logic             tick_last;
	logic             win_last;
	logic             end_q;

	assign tick_last = (pre == PRE_W'(TICK_CYCLES - 1));
	assign win_last  = tick_last && (ticks == limit - 1'b1); // last clock of the window

	always_ff @(posedge clki) begin
		if (!rst_n || !cfg.run) begin // held at zero until run
			pre   <= '0;
			ticks <= '0;
			limit <= cfg.integ_ticks;
			end_q <= 1'b0;
		end else begin
			end_q <= win_last;
			if (tick_last) begin
				pre <= '0;
				if (win_last) begin
					ticks <= '0;
					limit <= cfg.integ_ticks;
				end else ticks <= ticks + 1'b1;
			end else pre <= pre + 1'b1;
		end
	end

	assign window_end = end_q & cfg.run; // a stop in flight eats the pulse

endmodule

`default_nettype wire

//--- verilog/pulse_counters.sv
// edges count 3 clocks after they reach pulse_in and a change of line_invert while running can add one edge
`timescale 1ns/1ps
`default_nettype none

module pulse_counters #(
	parameter int NUM_INPUTS      = 4,
	parameter int NUM_CORRELATORS = 6,
	parameter int RESOLUTION      = 16
) (
	input  wire                    clki,
	input  wire                    rst_n,
	input  wire [NUM_INPUTS-1:0]   pulse_in,
	input  wire                    window_end,
	xc_cfg_if.user                 cfg,
	xc_snap_if.src                 snp,
	output logic [NUM_INPUTS-1:0]  overflow
);
	localparam int                    NUM_CNT = NUM_INPUTS + NUM_CORRELATORS;
	localparam logic [RESOLUTION-1:0] CNT_MAX = '1;

	logic [NUM_INPUTS-1:0]         sync1;   // first synchronizer stage
	logic [NUM_INPUTS-1:0]         sync2;
	logic [NUM_INPUTS-1:0]         level;   // after polarity
	logic [NUM_INPUTS-1:0]         level_q; // edge register
	logic [NUM_INPUTS-1:0]         edges;
	logic [NUM_CORRELATORS-1:0]    coinc;
	logic [NUM_CNT-1:0]            inc;     // pairs above lines
	logic [NUM_CNT*RESOLUTION-1:0] cnt_flat;
	logic [NUM_CNT*RESOLUTION-1:0] snap_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input conditioning
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clki) begin
		if (!rst_n) begin
			sync1   <= '0;
			sync2   <= '0;
			level_q <= '0;
		end else begin
			sync1   <= pulse_in;
			sync2   <= sync1;
			level_q <= level;
		end
	end

	assign level = sync2 ^ cfg.line_invert;
	assign edges = level & ~level_q & cfg.line_enable & {NUM_INPUTS{cfg.run}}; // rising only

	// same-cycle edges on both lines of a pair
	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_INPUTS; j++) begin : g_col
			assign coinc[xc_pkg::pair_index(i, j, NUM_INPUTS)] = edges[i] & edges[j];
		end
	end

	assign inc = {coinc, edges};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// saturating counters, lines then pairs
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar k = 0; k < NUM_CNT; k++) begin : g_cnt
		logic [RESOLUTION-1:0] cnt;
		always_ff @(posedge clki) begin
			if (!rst_n || !cfg.run) begin
				cnt <= '0;
			end else if (window_end) begin
				cnt <= {{(RESOLUTION-1){1'b0}}, inc[k]}; // new window keeps this edge
			end else if (inc[k] && cnt != CNT_MAX) begin
				cnt <= cnt + 1'b1;                       // holds at max
			end
		end
		assign cnt_flat[k*RESOLUTION +: RESOLUTION] = cnt;
	end

	always_ff @(posedge clki) begin
		if (!rst_n || !cfg.run) begin
			overflow <= '0;
			snp.snap <= 1'b0;
		end else begin
			snp.snap <= window_end; // snapshot valid with it
			for (int a = 0; a < NUM_INPUTS; a++) begin
				if (window_end) overflow[a] <= 1'b0;
				else if (cnt_flat[a*RESOLUTION +: RESOLUTION] == CNT_MAX) overflow[a] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clki) begin
		if (window_end) snap_q <= cnt_flat;
	end

	assign snp.line_count = snap_q[NUM_INPUTS*RESOLUTION-1:0];
	assign snp.pair_count = snap_q[NUM_CNT*RESOLUTION-1:NUM_INPUTS*RESOLUTION];

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
// 8N1 only, needs at least 4 clocks per bit, and valid comes in the middle of the stop bit
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLK_FREQUENCY = 50_000_000,
	parameter int BAUD_RATE     = 57600
) (
	input  wire        clki,
	input  wire        rst_n,
	input  wire        rx,
	output logic [7:0] data,
	output logic       valid
);
	localparam int CPB   = CLK_FREQUENCY / BAUD_RATE; // clocks per bit
	localparam int HALF  = CPB / 2;
	localparam int CNT_W = $clog2(CPB);

	typedef enum logic [1:0] {rs_idle, rs_start, rs_data, rs_stop} rx_state_e;

	rx_state_e      state;
	logic [1:0]     rx_sync;  // two-flop synchronizer, [1] is safe to use
	logic [CNT_W-1:0] timer;
	logic [2:0]     bit_cnt;
	logic [7:0]     shift_q;  // lsb arrives first

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;     // idle line is high
			state   <= rs_idle;
			timer   <= '0;
			bit_cnt <= '0;
			valid   <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			valid   <= 1'b0;
			case (state)
				rs_idle: if (!rx_sync[1]) begin
					state <= rs_start;
					timer <= '0;
				end
				rs_start: if (timer == CNT_W'(HALF - 1)) begin
					timer   <= '0;
					bit_cnt <= '0;
					if (rx_sync[1]) state <= rs_idle; // glitch, not a start bit
					else state <= rs_data;
				end else timer <= timer + 1'b1;
				rs_data: if (timer == CNT_W'(CPB - 1)) begin
					timer   <= '0;
					shift_q <= {rx_sync[1], shift_q[7:1]}; // mid-bit sample
					if (bit_cnt == 3'd7) state <= rs_stop;
					else bit_cnt <= bit_cnt + 1'b1;
				end else timer <= timer + 1'b1;
				rs_stop: if (timer == CNT_W'(CPB - 1)) begin
					state <= rs_idle;
					if (rx_sync[1]) begin  // bad stop bit drops the byte
						data  <= shift_q;
						valid <= 1'b1;
					end
				end else timer <= timer + 1'b1;
				default: state <= rs_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
// 8N1 only, start is ignored while busy is high and busy drops when the stop bit ends
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLK_FREQUENCY = 50_000_000,
	parameter int BAUD_RATE     = 57600
) (
	input  wire       clki,
	input  wire       rst_n,
	input  wire       start,
	input  wire [7:0] data,
	output logic      tx,
	output logic      busy
);
	localparam int CPB   = CLK_FREQUENCY / BAUD_RATE;
	localparam int CNT_W = $clog2(CPB);

	logic [9:0]       shift_q; // stop, data, start, bit 0 on the line
	logic [CNT_W-1:0] timer;
	logic [3:0]       bit_cnt;
	logic             bit_end;

	assign bit_end = (timer == CNT_W'(CPB - 1));

	always_ff @(posedge clki) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			timer   <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			timer   <= '0;
			bit_cnt <= '0;
			busy    <= start;
		end else if (bit_end) begin
			timer <= '0;
			if (bit_cnt == 4'd9) busy <= 1'b0; // stop bit done
			else bit_cnt <= bit_cnt + 1'b1;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	always_ff @(posedge clki) begin
		if (!busy && start) shift_q <= {1'b1, data, 1'b0};
		else if (busy && bit_end) shift_q <= {1'b1, shift_q[9:1]};
	end

	assign tx = busy ? shift_q[0] : 1'b1; // line idles high

endmodule

`default_nettype wire

//--- verilog/xc_control.sv
// bytes are taken one per rx_valid strobe and a mask byte only uses its low NUM_INPUTS bits
`timescale 1ns/1ps
`default_nettype none

module xc_control #(
	parameter int NUM_INPUTS = 4
) (
	input  wire       clki,
	input  wire       rst_n,
	input  wire [7:0] rx_data,
	input  wire       rx_valid,
	xc_cfg_if.ctrl    cfg
);
	xc_pkg::ctrl_state_e       state;
	logic                      mask_inv; // pending mask goes to invert
	logic [7:0]                time_hi;  // held until the low byte shows up
	logic [xc_pkg::TIME_W-1:0] time_new;

	assign time_new = {time_hi, rx_data};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clki) begin
		if (!rst_n) begin
			state           <= xc_pkg::st_idle;
			mask_inv        <= 1'b0;
			cfg.run         <= 1'b0;
			cfg.line_enable <= '1; // all lines on
			cfg.line_invert <= '0;
			cfg.integ_ticks <= {{(xc_pkg::TIME_W-1){1'b0}}, 1'b1};
		end else if (rx_valid) begin
			case (state)
				xc_pkg::st_idle: begin
					case (rx_data)
						xc_pkg::op_set_time: state <= xc_pkg::st_time_hi;
						xc_pkg::op_set_enable: begin
							state    <= xc_pkg::st_mask;
							mask_inv <= 1'b0;
						end
						xc_pkg::op_set_invert: begin
							state    <= xc_pkg::st_mask;
							mask_inv <= 1'b1;
						end
						xc_pkg::op_start: cfg.run <= 1'b1; // timer restarts on the rise
						xc_pkg::op_stop:  cfg.run <= 1'b0; // counts cleared downstream
						default: ;                          // unknown byte
					endcase
				end
				xc_pkg::st_time_hi: begin
					time_hi <= rx_data;
					state   <= xc_pkg::st_time_lo;
				end
				xc_pkg::st_time_lo: begin
					// zero would never end a window
					if (time_new == '0) cfg.integ_ticks <= {{(xc_pkg::TIME_W-1){1'b0}}, 1'b1};
					else cfg.integ_ticks <= time_new;
					state <= xc_pkg::st_idle;
				end
				xc_pkg::st_mask: begin
					if (mask_inv) cfg.line_invert <= rx_data[NUM_INPUTS-1:0];
					else cfg.line_enable <= rx_data[NUM_INPUTS-1:0];
					state <= xc_pkg::st_idle;
				end
				default: state <= xc_pkg::st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/xc_if.sv
// both interfaces take their widths as parameters and must be given the same values as the modules
`timescale 1ns/1ps
`default_nettype none

// configuration from the command parser
interface xc_cfg_if #(
	parameter int NUM_INPUTS = 4
);
	logic                        run;         // integration running
	logic [NUM_INPUTS-1:0]       line_enable; // 1 lets the line count
	logic [NUM_INPUTS-1:0]       line_invert; // 1 counts falling input edges
	logic [xc_pkg::TIME_W-1:0]   integ_ticks; // window length, never 0

	modport ctrl (output run, line_enable, line_invert, integ_ticks);
	modport user (input run, line_enable, line_invert, integ_ticks);
endinterface

// latched counts on their way to the frame sender
interface xc_snap_if #(
	parameter int NUM_INPUTS      = 4,
	parameter int NUM_CORRELATORS = 6,
	parameter int RESOLUTION      = 16
);
	logic                                  snap;       // one cycle, counts valid from here
	logic [NUM_INPUTS*RESOLUTION-1:0]      line_count; // line a at a*RESOLUTION
	logic [NUM_CORRELATORS*RESOLUTION-1:0] pair_count; // slot from xc_pkg::pair_index
	logic                                  busy;       // frame in flight, snaps dropped

	modport src (output snap, line_count, pair_count, input busy);
	modport dst (input snap, line_count, pair_count, output busy);
endinterface

`default_nettype wire

//--- verilog/xc_pkg.sv
// every line mask travels in one command byte so NUM_INPUTS must stay between 2 and 8
`default_nettype none

package xc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// command set
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [7:0] {
		op_set_time   = 8'h01, // then time hi, time lo
		op_set_enable = 8'h02, // then one mask byte
		op_set_invert = 8'h03, // then one mask byte
		op_start      = 8'h04,
		op_stop       = 8'h05
	} xc_op_e;                 // any other byte falls through the parser

	typedef enum logic [1:0] {
		st_idle,               // waiting for an opcode
		st_time_hi,
		st_time_lo,
		st_mask                // target mask picked by the opcode
	} ctrl_state_e;

	localparam logic [7:0] FRAME_HEADER = 8'hA5; // leads every frame
	localparam int         TIME_W       = 16;    // window length in ticks

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// width helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic int num_pairs(input int n);
		return n * (n - 1) / 2;
	endfunction

	// slot of pair i<j, upper triangle walked row by row
	// n=4 gives (0,1)=0 (0,2)=1 (0,3)=2 (1,2)=3 (1,3)=4 (2,3)=5
	function automatic int pair_index(input int i, input int j, input int n);
		return i * n - i * (i + 1) / 2 + (j - i - 1);
	endfunction

	// header byte plus every count, counts are whole bytes
	function automatic int frame_bytes(input int ni, input int nc, input int res);
		return 1 + (ni + nc) * res / 8;
	endfunction

endpackage

`default_nettype wire
